// File: design/zmem_params.svh
// memory-paging core constants
// bus widths, fixed RAM pages and DRAM/ROM strobe timing
`ifndef ZMEM_PARAMS_SVH
`define ZMEM_PARAMS_SVH

// cpu side
`define ZMEM_ADDR_W 16
`define ZMEM_DATA_W 8

// external memories
`define ZMEM_DRAM_A_W 8
`define ZMEM_DRAM_D_W 16
`define ZMEM_ROM_A_W 15

// RAM page number and the pages fixed to windows 1 and 2
`define ZMEM_PAGE_W 3
`define ZMEM_WIN1_PAGE 5
`define ZMEM_WIN2_PAGE 2

// RAS low before CAS falls
`define ZMEM_RAS_CYCLES 2

// CAS low time
`define ZMEM_CAS_CYCLES 2

// ROM output enable low time
`define ZMEM_ROM_CYCLES 3

`endif

// File: design/zmem_pkg.sv
// memory-paging core types
// cpu address word with memory and I/O views, plus access kinds
`include "zmem_params.svh"

package zmem_pkg;

	// memory view: 16K window number and offset inside it
	typedef struct packed {
		logic [1:0]              window;
		logic [`ZMEM_ADDR_W-3:0] offset;
	} mem_addr_t;

	// I/O view: port address as two bytes
	typedef struct packed {
		logic [`ZMEM_ADDR_W/2-1:0] hi;
		logic [`ZMEM_ADDR_W/2-1:0] lo;
	} io_addr_t;

	typedef union packed {
		mem_addr_t mem;
		io_addr_t  io;
	} cpu_addr_u;

	// ROM writes are accepted on the bus but go nowhere
	typedef enum logic [2:0] {
		ACC_ROM_RD = 3'd0,
		ACC_ROM_WR = 3'd1,
		ACC_RAM_RD = 3'd2,
		ACC_RAM_WR = 3'd3,
		ACC_IO_RD  = 3'd4,
		ACC_IO_WR  = 3'd5
	} access_kind_e;

endpackage

// File: design/zbus_capture.sv
// Wishbone classic slave front end
// takes one access per strobe, passes it on and returns the ack
`timescale 1ns/1ps
`include "zmem_params.svh"

module zbus_capture (
	input  logic                    fclk,
	input  logic                    rst_n,
	input  logic [`ZMEM_ADDR_W-1:0] wb_adr,
	input  logic [`ZMEM_DATA_W-1:0] wb_dat_w,
	input  logic                    wb_we,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_tga_io,
	input  logic                    seq_done,
	input  logic [`ZMEM_DATA_W-1:0] seq_rdata,
	output logic                    wb_ack,
	output logic [`ZMEM_DATA_W-1:0] wb_dat_r,
	output logic                    cap_valid,
	output zmem_pkg::cpu_addr_u     cap_addr,
	output logic                    cap_we,
	output logic                    cap_io,
	output logic [`ZMEM_DATA_W-1:0] cap_dat
);

	logic busy;
	logic take;
	logic accept;

	// ack still high blocks a strobe the master has not yet dropped
	assign accept = wb_cyc && wb_stb && !busy && !wb_ack;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy      <= 1'b0;
			take      <= 1'b0;
			cap_valid <= 1'b0;
			wb_ack    <= 1'b0;
		end
		else
		begin
			take      <= accept;
			cap_valid <= take;
			wb_ack    <= seq_done;
			if (accept)
				busy <= 1'b1;
			else if (seq_done)
				busy <= 1'b0;
		end
	end

	// request fields, held for the whole access
	always_ff @(posedge fclk)
	begin
		if (accept)
		begin
			cap_addr <= wb_adr;
			cap_we   <= wb_we;
			cap_io   <= wb_tga_io;
			cap_dat  <= wb_dat_w;
		end
		if (seq_done)
			wb_dat_r <= seq_rdata;
	end

	// master must keep the strobe up until it sees the ack
	a_stb_held: assert property (@(posedge fclk) disable iff (!rst_n)
		busy |-> (wb_cyc && wb_stb));

	// done from the sequencer is a pulse, so ack never stretches
	a_ack_pulse: assert property (@(posedge fclk) disable iff (!rst_n)
		wb_ack |=> !wb_ack);

endmodule

// File: design/page_mapper.sv
// 128K paging register and address mapper
// picks ROM or a DRAM page per 16K window and splits the DRAM address
`timescale 1ns/1ps
`include "zmem_params.svh"

module page_mapper (
	input  logic                      fclk,
	input  logic                      rst_n,
	input  logic                      cap_valid,
	input  zmem_pkg::cpu_addr_u       cap_addr,
	input  logic                      cap_we,
	input  logic                      cap_io,
	input  logic [`ZMEM_DATA_W-1:0]   cap_dat,
	output logic                      map_valid,
	output zmem_pkg::access_kind_e    map_kind,
	output logic [`ZMEM_DRAM_A_W-1:0] map_dram_row,
	output logic [`ZMEM_DRAM_A_W-1:0] map_dram_col,
	output logic                      map_lane,
	output logic [`ZMEM_ROM_A_W-1:0]  map_rom_a,
	output logic [`ZMEM_DATA_W-1:0]   map_dat
);

	import zmem_pkg::*;

	localparam int PHYS_W = `ZMEM_PAGE_W + `ZMEM_ADDR_W - 2;

	logic [`ZMEM_PAGE_W-1:0] ram_page;
	logic                    rom_page;
	logic                    lock;
	logic                    port_wr;
	logic [`ZMEM_PAGE_W-1:0] page;
	logic [PHYS_W-1:0]       phys;
	access_kind_e            kind;

	// partial decode: A15 and A1 low
	assign port_wr = cap_valid && cap_io && cap_we && !lock
		&& !cap_addr.io.hi[7] && !cap_addr.io.lo[1];

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ram_page <= '0;
			rom_page <= 1'b0;
			lock     <= 1'b0;
		end
		else if (port_wr)
		begin
			ram_page <= cap_dat[2:0];
			rom_page <= cap_dat[4];
			lock     <= cap_dat[5];
		end
	end

	always_comb
	begin
		case (cap_addr.mem.window)
			2'd1:    page = `ZMEM_PAGE_W'(`ZMEM_WIN1_PAGE);
			2'd2:    page = `ZMEM_PAGE_W'(`ZMEM_WIN2_PAGE);
			2'd3:    page = ram_page;
			default: page = '0;
		endcase
	end

	assign phys = {page, cap_addr.mem.offset};

	always_comb
	begin
		if (cap_io)
			kind = cap_we ? ACC_IO_WR : ACC_IO_RD;
		else if (cap_addr.mem.window == 2'd0)
			kind = cap_we ? ACC_ROM_WR : ACC_ROM_RD;
		else
			kind = cap_we ? ACC_RAM_WR : ACC_RAM_RD;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			map_valid <= 1'b0;
		else
			map_valid <= cap_valid;
	end

	// row/col/lane from the 17-bit physical byte address
	always_ff @(posedge fclk)
	begin
		if (cap_valid)
		begin
			map_kind     <= kind;
			map_dram_row <= phys[PHYS_W-1:`ZMEM_DRAM_A_W+1];
			map_dram_col <= phys[`ZMEM_DRAM_A_W:1];
			map_lane     <= phys[0];
			map_rom_a    <= {rom_page, cap_addr.mem.offset};
			map_dat      <= cap_dat;
		end
	end

	// once locked, the paging state holds until reset
	a_lock_holds: assert property (@(posedge fclk) disable iff (!rst_n)
		lock |=> $stable({ram_page, rom_page, lock}));

endmodule

// File: design/dram_sequencer.sv
// DRAM and ROM strobe sequencer
// RAS then CAS per lane for RAM, an OE window for ROM, then done
`timescale 1ns/1ps
`include "zmem_params.svh"

module dram_sequencer (
	input  logic                      fclk,
	input  logic                      rst_n,
	input  logic                      map_valid,
	input  zmem_pkg::access_kind_e    map_kind,
	input  logic [`ZMEM_DRAM_A_W-1:0] map_dram_row,
	input  logic [`ZMEM_DRAM_A_W-1:0] map_dram_col,
	input  logic                      map_lane,
	input  logic [`ZMEM_ROM_A_W-1:0]  map_rom_a,
	input  logic [`ZMEM_DATA_W-1:0]   map_dat,
	input  logic [`ZMEM_DRAM_D_W-1:0] rd_rdata,
	input  logic [`ZMEM_DATA_W-1:0]   rom_d,
	output logic                      seq_done,
	output logic [`ZMEM_DATA_W-1:0]   seq_rdata,
	output logic [`ZMEM_DRAM_A_W-1:0] ra,
	output logic [`ZMEM_DRAM_D_W-1:0] rd_wdata,
	output logic                      rras_n,
	output logic                      rucas_n,
	output logic                      rlcas_n,
	output logic                      rwe_n,
	output logic [`ZMEM_ROM_A_W-1:0]  rom_a,
	output logic                      romoe_n
);

	import zmem_pkg::*;

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_RAS  = 2'd1;
	localparam logic [1:0] S_CAS  = 2'd2;
	localparam logic [1:0] S_ROM  = 2'd3;

	localparam logic [2:0] RAS_LOAD = 3'(`ZMEM_RAS_CYCLES - 1);
	localparam logic [2:0] CAS_LOAD = 3'(`ZMEM_CAS_CYCLES - 1);
	localparam logic [2:0] ROM_LOAD = 3'(`ZMEM_ROM_CYCLES - 1);

	logic [1:0]                state;
	logic [2:0]                cnt;
	logic                      start;
	logic                      cnt_end;
	logic                      lane_q;
	logic [`ZMEM_DRAM_A_W-1:0] col_q;

	assign start   = map_valid && (state == S_IDLE);
	assign cnt_end = (cnt == 3'd0);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= S_IDLE;
			cnt      <= 3'd0;
			rras_n   <= 1'b1;
			rucas_n  <= 1'b1;
			rlcas_n  <= 1'b1;
			rwe_n    <= 1'b1;
			romoe_n  <= 1'b1;
			seq_done <= 1'b0;
		end
		else
		begin
			seq_done <= 1'b0;
			case (state)
				S_IDLE:
				begin
					if (map_valid)
					begin
						case (map_kind)
							ACC_RAM_RD, ACC_RAM_WR:
							begin
								rras_n <= 1'b0;
								// early write, WE down before CAS
								rwe_n  <= (map_kind != ACC_RAM_WR);
								cnt    <= RAS_LOAD;
								state  <= S_RAS;
							end
							ACC_ROM_RD:
							begin
								romoe_n <= 1'b0;
								cnt     <= ROM_LOAD;
								state   <= S_ROM;
							end
							// I/O and ROM writes need no strobes
							default: seq_done <= 1'b1;
						endcase
					end
				end
				S_RAS:
				begin
					if (cnt_end)
					begin
						// lane 0 is the upper byte
						rucas_n <= lane_q;
						rlcas_n <= !lane_q;
						cnt     <= CAS_LOAD;
						state   <= S_CAS;
					end
					else
						cnt <= cnt - 3'd1;
				end
				S_CAS:
				begin
					if (cnt_end)
					begin
						rras_n   <= 1'b1;
						rucas_n  <= 1'b1;
						rlcas_n  <= 1'b1;
						rwe_n    <= 1'b1;
						seq_done <= 1'b1;
						state    <= S_IDLE;
					end
					else
						cnt <= cnt - 3'd1;
				end
				default:
				begin
					if (cnt_end)
					begin
						romoe_n  <= 1'b1;
						seq_done <= 1'b1;
						state    <= S_IDLE;
					end
					else
						cnt <= cnt - 3'd1;
				end
			endcase
		end
	end

	// addresses, write data and read data
	always_ff @(posedge fclk)
	begin
		if (start)
		begin
			ra       <= map_dram_row;
			col_q    <= map_dram_col;
			lane_q   <= map_lane;
			rom_a    <= map_rom_a;
			rd_wdata <= {map_dat, map_dat};
			if (map_kind inside {ACC_IO_RD, ACC_IO_WR, ACC_ROM_WR})
				seq_rdata <= 8'hFF;
		end
		if (state == S_RAS && cnt_end)
			ra <= col_q;
		if (state == S_CAS && cnt_end)
			seq_rdata <= lane_q ? rd_rdata[7:0] : rd_rdata[15:8];
		if (state == S_ROM && cnt_end)
			seq_rdata <= rom_d;
	end

	// DRAM and ROM share no cycle
	a_no_overlap: assert property (@(posedge fclk) disable iff (!rst_n)
		rras_n || romoe_n);

	// the one-at-a-time bus keeps new work away while busy
	a_idle_on_valid: assert property (@(posedge fclk) disable iff (!rst_n)
		map_valid |-> (state == S_IDLE));

endmodule

// File: design/zmem_top.sv
// memory-paging core top
// Wishbone capture, page mapper and DRAM/ROM sequencer in a chain
`timescale 1ns/1ps
`include "zmem_params.svh"

module zmem_top (
	input  logic                      fclk,
	input  logic                      rst_n,
	input  logic [`ZMEM_ADDR_W-1:0]   wb_adr,
	input  logic [`ZMEM_DATA_W-1:0]   wb_dat_w,
	input  logic                      wb_we,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_tga_io,
	output logic                      wb_ack,
	output logic [`ZMEM_DATA_W-1:0]   wb_dat_r,
	output logic [`ZMEM_DRAM_A_W-1:0] ra,
	output logic [`ZMEM_DRAM_D_W-1:0] rd_wdata,
	input  logic [`ZMEM_DRAM_D_W-1:0] rd_rdata,
	output logic                      rras_n,
	output logic                      rucas_n,
	output logic                      rlcas_n,
	output logic                      rwe_n,
	output logic [`ZMEM_ROM_A_W-1:0]  rom_a,
	input  logic [`ZMEM_DATA_W-1:0]   rom_d,
	output logic                      romoe_n
);

	import zmem_pkg::*;

	// capture to mapper
	logic                      cap_valid;
	cpu_addr_u                 cap_addr;
	logic                      cap_we;
	logic                      cap_io;
	logic [`ZMEM_DATA_W-1:0]   cap_dat;

	// mapper to sequencer
	logic                      map_valid;
	access_kind_e              map_kind;
	logic [`ZMEM_DRAM_A_W-1:0] map_dram_row;
	logic [`ZMEM_DRAM_A_W-1:0] map_dram_col;
	logic                      map_lane;
	logic [`ZMEM_ROM_A_W-1:0]  map_rom_a;
	logic [`ZMEM_DATA_W-1:0]   map_dat;

	// sequencer back to capture
	logic                      seq_done;
	logic [`ZMEM_DATA_W-1:0]   seq_rdata;

	zbus_capture zbus_capture_inst (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_we     (wb_we),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_tga_io (wb_tga_io),
		.seq_done  (seq_done),
		.seq_rdata (seq_rdata),
		.wb_ack    (wb_ack),
		.wb_dat_r  (wb_dat_r),
		.cap_valid (cap_valid),
		.cap_addr  (cap_addr),
		.cap_we    (cap_we),
		.cap_io    (cap_io),
		.cap_dat   (cap_dat)
	);

	page_mapper page_mapper_inst (
		.fclk         (fclk),
		.rst_n        (rst_n),
		.cap_valid    (cap_valid),
		.cap_addr     (cap_addr),
		.cap_we       (cap_we),
		.cap_io       (cap_io),
		.cap_dat      (cap_dat),
		.map_valid    (map_valid),
		.map_kind     (map_kind),
		.map_dram_row (map_dram_row),
		.map_dram_col (map_dram_col),
		.map_lane     (map_lane),
		.map_rom_a    (map_rom_a),
		.map_dat      (map_dat)
	);

	dram_sequencer dram_sequencer_inst (
		.fclk         (fclk),
		.rst_n        (rst_n),
		.map_valid    (map_valid),
		.map_kind     (map_kind),
		.map_dram_row (map_dram_row),
		.map_dram_col (map_dram_col),
		.map_lane     (map_lane),
		.map_rom_a    (map_rom_a),
		.map_dat      (map_dat),
		.rd_rdata     (rd_rdata),
		.rom_d        (rom_d),
		.seq_done     (seq_done),
		.seq_rdata    (seq_rdata),
		.ra           (ra),
		.rd_wdata     (rd_wdata),
		.rras_n       (rras_n),
		.rucas_n      (rucas_n),
		.rlcas_n      (rlcas_n),
		.rwe_n        (rwe_n),
		.rom_a        (rom_a),
		.romoe_n      (romoe_n)
	);

endmodule

// File: testbench/zmem_mem_models.sv
// behavioral DRAM and ROM for the memory-paging core
// 16-bit DRAM with byte lanes and a ROM whose data follows its address
`timescale 1ns/1ps
`include "zmem_params.svh"

module dram_model (
	input  logic [`ZMEM_DRAM_A_W-1:0] ra,
	input  logic [`ZMEM_DRAM_D_W-1:0] rd_wdata,
	input  logic                      rras_n,
	input  logic                      rucas_n,
	input  logic                      rlcas_n,
	input  logic                      rwe_n,
	output logic [`ZMEM_DRAM_D_W-1:0] rd_rdata
);

	logic [`ZMEM_DRAM_D_W-1:0] mem [0:65535];
	logic [`ZMEM_DRAM_A_W-1:0] row_q;
	logic [`ZMEM_DRAM_A_W-1:0] col_q;

	// the controller moves ra together with the strobe, so look a little later
	always @(negedge rras_n)
	begin
		#1;
		row_q = ra;
	end

	always @(negedge rucas_n or negedge rlcas_n)
	begin
		#1;
		col_q = ra;
		if (!rwe_n)
		begin
			if (!rucas_n)
				mem[{row_q, col_q}][15:8] = rd_wdata[15:8];
			if (!rlcas_n)
				mem[{row_q, col_q}][7:0] = rd_wdata[7:0];
		end
	end

	assign rd_rdata = mem[{row_q, col_q}];

endmodule

module rom_model (
	input  logic [`ZMEM_ROM_A_W-1:0] rom_a,
	input  logic                     romoe_n,
	output logic [`ZMEM_DATA_W-1:0]  rom_d
);

	// page bit folded into the top data bit
	assign rom_d = romoe_n ? 8'hFF : (rom_a[7:0] ^ {rom_a[`ZMEM_ROM_A_W-1], 7'h2A});

endmodule

// File: testbench/tb_zmem.sv
// memory-paging core testbench
// runs Wishbone accesses from a data file against DRAM and ROM models
`timescale 1ns/1ps
`include "zmem_params.svh"

module tb_zmem;

	localparam int MAX_LINES = 64;
	localparam int FIELDS    = 5;

	logic                      fclk;
	logic                      rst_n;
	logic [`ZMEM_ADDR_W-1:0]   wb_adr;
	logic [`ZMEM_DATA_W-1:0]   wb_dat_w;
	logic                      wb_we;
	logic                      wb_cyc;
	logic                      wb_stb;
	logic                      wb_tga_io;
	logic                      wb_ack;
	logic [`ZMEM_DATA_W-1:0]   wb_dat_r;
	logic [`ZMEM_DRAM_A_W-1:0] ra;
	logic [`ZMEM_DRAM_D_W-1:0] rd_wdata;
	logic [`ZMEM_DRAM_D_W-1:0] rd_rdata;
	logic                      rras_n;
	logic                      rucas_n;
	logic                      rlcas_n;
	logic                      rwe_n;
	logic [`ZMEM_ROM_A_W-1:0]  rom_a;
	logic [`ZMEM_DATA_W-1:0]   rom_d;
	logic                      romoe_n;

	// per line the test, op, address, write data and expected read data
	logic [15:0] stim [0:MAX_LINES*FIELDS-1];

	int n_lines;
	int cycle_limit;
	int cycle_count;
	int ack_count;
	int acks_expected;
	int ras_count;
	int err_count;
	int check_count;
	int test_count;

	zmem_top zmem_top_inst (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_we     (wb_we),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_tga_io (wb_tga_io),
		.wb_ack    (wb_ack),
		.wb_dat_r  (wb_dat_r),
		.ra        (ra),
		.rd_wdata  (rd_wdata),
		.rd_rdata  (rd_rdata),
		.rras_n    (rras_n),
		.rucas_n   (rucas_n),
		.rlcas_n   (rlcas_n),
		.rwe_n     (rwe_n),
		.rom_a     (rom_a),
		.rom_d     (rom_d),
		.romoe_n   (romoe_n)
	);

	dram_model dram_model_inst (
		.ra       (ra),
		.rd_wdata (rd_wdata),
		.rras_n   (rras_n),
		.rucas_n  (rucas_n),
		.rlcas_n  (rlcas_n),
		.rwe_n    (rwe_n),
		.rd_rdata (rd_rdata)
	);

	rom_model rom_model_inst (
		.rom_a   (rom_a),
		.romoe_n (romoe_n),
		.rom_d   (rom_d)
	);

	always #2 fclk = ~fclk;

	// cycle counter and ack count
	always @(posedge fclk)
	begin
		cycle_count = cycle_count + 1;
		if (wb_ack === 1'b1)
			ack_count = ack_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// one RAS strobe per DRAM access
	always @(negedge rras_n)
	begin
		ras_count = ras_count + 1;
	end

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		check_count = check_count + 1;
		if (got !== exp)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			err_count = err_count + 1;
		end
	endtask

	// op 0 memory read, 1 memory write, 2 I/O write, 3 I/O read
	task automatic run_access(input logic [3:0] op, input logic [15:0] addr,
		input logic [7:0] wdat, input logic [7:0] exp);
		int ras_before;
		int ras_expected;
		ras_before = ras_count;
		// only memory cycles outside window 0 reach the DRAM
		if (op <= 4'd1 && addr[15:14] != 2'd0)
			ras_expected = 1;
		else
			ras_expected = 0;
		wb_adr    = addr;
		wb_dat_w  = wdat;
		wb_we     = (op == 4'd1) || (op == 4'd2);
		wb_tga_io = (op == 4'd2) || (op == 4'd3);
		wb_cyc    = 1'b1;
		wb_stb    = 1'b1;
		@(negedge fclk);
		while (wb_ack !== 1'b1)
			@(negedge fclk);
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_tga_io = 1'b0;
		if (op == 4'd0 || op == 4'd3)
			check_value($sformatf("wb_dat_r @%h", addr), 16'(wb_dat_r), 16'(exp));
		// two idle cycles would show a repeated ack
		@(negedge fclk);
		@(negedge fclk);
		acks_expected = acks_expected + 1;
		check_value($sformatf("wb_ack count @%h", addr), 16'(ack_count),
			16'(acks_expected));
		check_value($sformatf("rras_n falls @%h", addr), 16'(ras_count - ras_before),
			16'(ras_expected));
	endtask

	task automatic report_test(input int tnum, input int errs);
		test_count = test_count + 1;
		if (errs == 0)
			$display("test %0d: ok", tnum);
		else
			$display("test %0d: %0d error(s)", tnum, errs);
	endtask

	initial
	begin
		int base;
		int cur_test;
		int errs_at_start;

		fclk          = 1'b0;
		rst_n         = 1'b0;
		wb_adr        = '0;
		wb_dat_w      = '0;
		wb_we         = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_tga_io     = 1'b0;
		cycle_limit   = 0;
		cycle_count   = 0;
		ack_count     = 0;
		acks_expected = 0;
		ras_count     = 0;
		err_count     = 0;
		check_count   = 0;
		test_count    = 0;

		// prefill with the end marker so a short or missing file stops the loop
		for (int i = 0; i < MAX_LINES*FIELDS; i++)
			stim[i] = 16'h00FF;
		$readmemh("testbench/zmem_input.txt", stim);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim[FIELDS*n_lines] != 16'h00FF)
			n_lines = n_lines + 1;
		cycle_limit = n_lines*12 + 50;
		if (n_lines == 0)
		begin
			$display("no stimulus lines could be read from the input file");
			err_count = err_count + 1;
		end

		repeat (5) @(negedge fclk);
		rst_n = 1'b1;
		@(negedge fclk);

		// reset state counts toward the first test
		errs_at_start = 0;
		check_value("wb_ack", 16'(wb_ack), 16'h0);
		check_value("rras_n", 16'(rras_n), 16'h1);
		check_value("rucas_n", 16'(rucas_n), 16'h1);
		check_value("rlcas_n", 16'(rlcas_n), 16'h1);
		check_value("rwe_n", 16'(rwe_n), 16'h1);
		check_value("romoe_n", 16'(romoe_n), 16'h1);

		cur_test = int'(stim[0]);
		for (int i = 0; i < n_lines; i++)
		begin
			base = FIELDS*i;
			if (int'(stim[base]) != cur_test)
			begin
				report_test(cur_test, err_count - errs_at_start);
				cur_test      = int'(stim[base]);
				errs_at_start = err_count;
			end
			run_access(stim[base+1][3:0], stim[base+2], stim[base+3][7:0],
				stim[base+4][7:0]);
		end
		if (n_lines > 0)
			report_test(cur_test, err_count - errs_at_start);

		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count,
			err_count);
		if (err_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: vlog.f
+incdir+design
design/zmem_pkg.sv
design/zbus_capture.sv
design/page_mapper.sv
design/dram_sequencer.sv
design/zmem_top.sv
testbench/zmem_mem_models.sv
testbench/tb_zmem.sv

// File: run_sim.sh
#!/bin/sh
# build the memory-paging core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_zmem -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_zmem)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

// File: testbench/zmem_input.txt
// test  op  addr  wdata  expect   (hex)
// op: 0 mem read, 1 mem write, 2 I/O write, 3 I/O read; test FF ends the list
01 0 0000 00 2A
01 0 1234 00 1E
01 0 3FFF 00 D5
02 1 4000 11 00
02 1 4001 22 00
02 1 8100 33 00
02 1 8101 44 00
02 0 4000 00 11
02 0 4001 00 22
02 0 8100 00 33
02 0 8101 00 44
03 2 7FFD 01 00
03 1 C000 5A 00
03 1 C001 A5 00
03 2 7FFD 05 00
03 0 C000 00 11
03 0 C001 00 22
03 2 7FFD 01 00
03 0 C000 00 5A
03 0 C001 00 A5
04 2 7FFD 10 00
04 0 0000 00 AA
04 0 1234 00 9E
04 1 1234 77 00
04 0 1234 00 9E
05 2 7FFD 23 00
05 1 C000 3C 00
05 2 7FFD 11 00
05 0 C000 00 3C
05 0 0000 00 2A
06 3 00FE 00 FF
06 3 7FFD 00 FF
FF 0 0000 00 00
